// ==== design/pwmGen_settings.svh ====
`ifndef PWMGEN_SETTINGS_SVH
`define PWMGEN_SETTINGS_SVH

// width of on-time, remainder and loss quantities
`define PWM_POS_WIDTH 16

// width of the PWM period length
`define PWM_PERIOD_WIDTH 12

// shortest on-time in clk cycles the MOSFET driver can follow
// anything shorter is carried into later periods
`define PWM_MIN_PULSE 32

`endif

// ==== design/pwmGenPkg.sv ====
`include "pwmGen_settings.svh"

package pwmGenPkg;

    // static configuration written by the host
    typedef struct packed {
        logic [`PWM_PERIOD_WIDTH-1:0] periodLen;
        logic                         enable;
    } pwmConfig_t;

    // per-step command from the commutation logic
    typedef struct packed {
        logic [`PWM_POS_WIDTH-1:0] pulseLen;
        logic                      stepStart;
        logic                      stepEnd;
    } stepCmd_t;

    // loss report valid for a single cycle after step end
    typedef struct packed {
        logic [`PWM_POS_WIDTH-1:0] lostMag;
        logic                      shortfall;
        logic                      valid;
    } lossReport_t;

    // what the carried remainder does next cycle
    typedef enum logic [1:0] {
        remainHold,
        remainClear,
        remainStoreSum
    } remainAction_t;

    // what the on-time counter does next cycle
    typedef enum logic [1:0] {
        onTimeCount,
        onTimeLoadSum,
        onTimeClear
    } onTimeAction_t;

endpackage

// ==== design/periodTimer.sv ====
`timescale 1ns/1ns
`include "pwmGen_settings.svh"

module periodTimer (
    input  logic                  clk,
    input  logic                  reset,
    input  pwmGenPkg::pwmConfig_t cfg,
    input  logic                  stepStart,
    output logic                  periodTick
);

    localparam int PeriodWidth = `PWM_PERIOD_WIDTH;

    logic [PeriodWidth-1:0] periodCount;
    logic                   lastCycle;

    // count of one marks the final cycle of a period
    assign lastCycle = (periodCount == PeriodWidth'(1));

    // a step start restarts the period, so no tick in that cycle
    assign periodTick = cfg.enable && !stepStart && lastCycle;

    always_ff @(posedge clk) begin
        if (reset) begin
            periodCount <= '0;
        end else if (!cfg.enable || stepStart || lastCycle) begin
            // a new period starts when disabled, at step start or after the last count
            periodCount <= cfg.periodLen;
        end else begin
            periodCount <= periodCount - PeriodWidth'(1);
        end
    end

endmodule

// ==== design/pwmSequencer.sv ====
`timescale 1ns/1ns

module pwmSequencer (
    input  logic                     enable,
    input  logic                     stepStart,
    input  logic                     periodTick,
    input  logic                     sumReachesMin,
    output pwmGenPkg::remainAction_t remainAction,
    output pwmGenPkg::onTimeAction_t onTimeAction
);

    import pwmGenPkg::*;

    // decision table in priority order
    //   disabled      clear remainder, clear on-time
    //   step start    clear remainder, clear on-time
    //   period tick   fire the sum, or carry it on
    //   otherwise     keep remainder, keep counting
    always_comb begin
        if (!enable) begin
            remainAction = remainClear;
            onTimeAction = onTimeClear;
        end else if (stepStart) begin
            // a new step drops whatever the old one still owed
            remainAction = remainClear;
            onTimeAction = onTimeClear;
        end else if (periodTick) begin
            if (sumReachesMin) begin
                // long enough for the driver so all of it is delivered
                remainAction = remainClear;
                onTimeAction = onTimeLoadSum;
            end else begin
                // too short to switch so it moves into the next period
                remainAction = remainStoreSum;
                onTimeAction = onTimeCount;
            end
        end else begin
            remainAction = remainHold;
            onTimeAction = onTimeCount;
        end
    end

endmodule

// ==== design/remainderAccumulator.sv ====
`timescale 1ns/1ns
`include "pwmGen_settings.svh"

module remainderAccumulator (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`PWM_POS_WIDTH-1:0] pulseLen,
    input  pwmGenPkg::remainAction_t  remainAction,
    output logic [`PWM_POS_WIDTH-1:0] sum,
    output logic                      sumReachesMin
);

    import pwmGenPkg::*;

    localparam int PosWidth = `PWM_POS_WIDTH;

    // on-time owed from earlier periods of this step
    logic [PosWidth-1:0] remainder;

    // on-time this period would deliver if it fired now
    assign sum = remainder + pulseLen;

    assign sumReachesMin = (sum >= PosWidth'(`PWM_MIN_PULSE));

    always_ff @(posedge clk) begin
        if (reset) begin
            remainder <= '0;
        end else begin
            case (remainAction)
                remainClear: begin
                    remainder <= '0;
                end
                remainStoreSum: begin
                    remainder <= sum;
                end
                default: begin
                    remainder <= remainder;
                end
            endcase
        end
    end

endmodule

// ==== design/onTimeCounter.sv ====
`timescale 1ns/1ns
`include "pwmGen_settings.svh"

module onTimeCounter (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`PWM_POS_WIDTH-1:0] sum,
    input  pwmGenPkg::onTimeAction_t  onTimeAction,
    output logic                      pwm
);

    import pwmGenPkg::*;

    localparam int PosWidth = `PWM_POS_WIDTH;

    // cycles of on-time still to drive
    logic [PosWidth-1:0] onCount;

    assign pwm = (onCount != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            onCount <= '0;
        end else begin
            case (onTimeAction)
                // a fresh load replaces any pulse still running
                onTimeLoadSum: onCount <= sum;
                onTimeClear:   onCount <= '0;
                default: begin
                    if (pwm) begin
                        onCount <= onCount - PosWidth'(1);
                    end
                end
            endcase
        end
    end

endmodule

// ==== design/lossMeter.sv ====
`timescale 1ns/1ns
`include "pwmGen_settings.svh"

module lossMeter (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      enable,
    input  logic [`PWM_POS_WIDTH-1:0] pulseLen,
    input  logic                      periodTick,
    input  logic                      pwm,
    input  logic                      stepEnd,
    output pwmGenPkg::lossReport_t    report
);

    localparam int PosWidth = `PWM_POS_WIDTH;

    logic [PosWidth-1:0] wantedTotal;
    logic [PosWidth-1:0] deliveredTotal;
    logic [PosWidth-1:0] wantedNext;
    logic [PosWidth-1:0] deliveredNext;
    logic [PosWidth-1:0] lostMag;
    logic                shortfall;

    // totals including this cycle's contribution
    assign wantedNext    = wantedTotal + (periodTick ? pulseLen : '0);
    assign deliveredNext = deliveredTotal + PosWidth'(pwm);

    // magnitude and sign of wanted minus delivered
    assign shortfall = (deliveredNext < wantedNext);
    assign lostMag   = shortfall ? (wantedNext - deliveredNext)
                                 : (deliveredNext - wantedNext);

    always_ff @(posedge clk) begin
        if (reset) begin
            wantedTotal    <= '0;
            deliveredTotal <= '0;
            report         <= '0;
        end else begin
            report.valid <= 1'b0;
            if (!enable) begin
                wantedTotal    <= '0;
                deliveredTotal <= '0;
            end else if (stepEnd) begin
                // close the step and start the next one from zero
                report.lostMag   <= lostMag;
                report.shortfall <= shortfall;
                report.valid     <= 1'b1;
                wantedTotal      <= '0;
                deliveredTotal   <= '0;
            end else begin
                wantedTotal    <= wantedNext;
                deliveredTotal <= deliveredNext;
            end
        end
    end

endmodule

// ==== design/pwmGenerator.sv ====
`timescale 1ns/1ns
`include "pwmGen_settings.svh"

module pwmGenerator (
    input  logic                   clk,
    input  logic                   reset,
    input  pwmGenPkg::pwmConfig_t  cfg,
    input  pwmGenPkg::stepCmd_t    step,
    output logic                   pwm,
    output pwmGenPkg::lossReport_t report
);

    import pwmGenPkg::*;

    localparam int PosWidth = `PWM_POS_WIDTH;

    logic                periodTick;
    logic                sumReachesMin;
    logic [PosWidth-1:0] sum;
    remainAction_t       remainAction;
    onTimeAction_t       onTimeAction;

    // period boundaries within the step
    periodTimer periodTimer_i (
        .clk        (clk),
        .reset      (reset),
        .cfg        (cfg),
        .stepStart  (step.stepStart),
        .periodTick (periodTick)
    );

    pwmSequencer pwmSequencer_i (
        .enable        (cfg.enable),
        .stepStart     (step.stepStart),
        .periodTick    (periodTick),
        .sumReachesMin (sumReachesMin),
        .remainAction  (remainAction),
        .onTimeAction  (onTimeAction)
    );

    remainderAccumulator remainderAccumulator_i (
        .clk           (clk),
        .reset         (reset),
        .pulseLen      (step.pulseLen),
        .remainAction  (remainAction),
        .sum           (sum),
        .sumReachesMin (sumReachesMin)
    );

    // pulse output
    onTimeCounter onTimeCounter_i (
        .clk          (clk),
        .reset        (reset),
        .sum          (sum),
        .onTimeAction (onTimeAction),
        .pwm          (pwm)
    );

    // wanted against delivered on-time per step
    lossMeter lossMeter_i (
        .clk        (clk),
        .reset      (reset),
        .enable     (cfg.enable),
        .pulseLen   (step.pulseLen),
        .periodTick (periodTick),
        .pwm        (pwm),
        .stepEnd    (step.stepEnd),
        .report     (report)
    );

endmodule

// ==== tb/pwmGeneratorModel.svh ====
`ifndef PWMGENERATOR_MODEL_SVH
`define PWMGENERATOR_MODEL_SVH

// model copy of every register in the design
logic [`PWM_PERIOD_WIDTH-1:0] mPeriodCount;
logic [`PWM_POS_WIDTH-1:0]    mRemainder;
logic [`PWM_POS_WIDTH-1:0]    mOnCount;
logic [`PWM_POS_WIDTH-1:0]    mWanted;
logic [`PWM_POS_WIDTH-1:0]    mDelivered;
logic [`PWM_POS_WIDTH-1:0]    mReportMag;
logic                         mReportShort;
logic                         mReportValid;

// pwm follows the remaining on-time
function automatic logic expectedPwm();
    return (mOnCount != '0);
endfunction

// one clock edge of the generator with the inputs seen in the cycle before it
function automatic void advanceModel(input logic rst, input pwmConfig_t c, input stepCmd_t s);
    logic                      tick;
    logic [`PWM_POS_WIDTH-1:0] sum;
    logic [`PWM_POS_WIDTH-1:0] countedDown;
    logic [`PWM_POS_WIDTH-1:0] wantedNow;
    logic [`PWM_POS_WIDTH-1:0] deliveredNow;
    tick         = c.enable && !s.stepStart && (mPeriodCount == 1);
    sum          = mRemainder + s.pulseLen;
    countedDown  = (mOnCount != '0) ? mOnCount - 1 : '0;
    wantedNow    = mWanted + (tick ? s.pulseLen : '0);
    deliveredNow = mDelivered + (mOnCount != '0);
    if (rst) begin
        mPeriodCount = '0;
        mRemainder   = '0;
        mOnCount     = '0;
        mWanted      = '0;
        mDelivered   = '0;
        mReportMag   = '0;
        mReportShort = 1'b0;
        mReportValid = 1'b0;
    end else begin
        mReportValid = 1'b0;
        // period boundaries restart on disable, step start and the last count
        if (!c.enable || s.stepStart || mPeriodCount == 1) begin
            mPeriodCount = c.periodLen;
        end else begin
            mPeriodCount = mPeriodCount - 1;
        end
        // pulse rule in priority order
        if (!c.enable || s.stepStart) begin
            mRemainder = '0;
            mOnCount   = '0;
        end else if (tick && sum >= `PWM_MIN_PULSE) begin
            mRemainder = '0;
            mOnCount   = sum;
        end else if (tick) begin
            mRemainder = sum;
            mOnCount   = countedDown;
        end else begin
            mOnCount = countedDown;
        end
        // loss totals for the step
        if (!c.enable) begin
            mWanted    = '0;
            mDelivered = '0;
        end else if (s.stepEnd) begin
            mReportValid = 1'b1;
            mReportShort = (deliveredNow < wantedNow);
            mReportMag   = mReportShort ? wantedNow - deliveredNow : deliveredNow - wantedNow;
            mWanted      = '0;
            mDelivered   = '0;
        end else begin
            mWanted    = wantedNow;
            mDelivered = deliveredNow;
        end
    end
endfunction

`endif

// ==== tb/pwmGeneratorTb.sv ====
`timescale 1ns/1ns
`include "pwmGen_settings.svh"

module pwmGeneratorTb;

    import pwmGenPkg::*;

    localparam int IdleCycles  = 40;
    localparam int SteadyLen   = 256;
    localparam int DeferLen    = 448;
    localparam int CarryLen    = 384;
    localparam int CutLen      = 80;
    localparam int ShortLen    = 72;
    localparam int RandomSteps = 24;
    localparam int TailCycles  = 10;
    // one report per enabled step
    localparam int ExpectedReports = 5 + RandomSteps;

    logic        clk;
    logic        reset;
    pwmConfig_t  cfg;
    stepCmd_t    step;
    logic        pwmOut;
    lossReport_t report;

    string       testName;
    int          cycleCount;
    int          cycleLimit;
    int          reportsSeen;
    int          runLen;
    int          lastPulseWidth;
    logic [31:0] rngState;
    int          randLen[RandomSteps];
    logic [15:0] randPulse[RandomSteps];

    `include "pwmGeneratorModel.svh"

    pwmGenerator pwmGenerator_i (
        .clk    (clk),
        .reset  (reset),
        .cfg    (cfg),
        .step   (step),
        .pwm    (pwmOut),
        .report (report)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s %s: expected %0d, actual %0d", testName, what, expected, actual);
            $display("Something failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // one step with its start strobe in the first cycle and end strobe in the last
    task automatic runStep(input logic [15:0] len, input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            step.pulseLen  <= len;
            step.stepStart <= (i == 0);
            step.stepEnd   <= (i == cycles - 1);
        end
    endtask

    task automatic setConfig(input logic en, input int len);
        @(posedge clk);
        cfg.enable     <= en;
        cfg.periodLen  <= len[`PWM_PERIOD_WIDTH-1:0];
        step.stepStart <= 1'b0;
        step.stepEnd   <= 1'b0;
    endtask

    // compare against the model, then let the model take the same edge as the DUT
    always @(negedge clk) begin
        if (!reset) begin
            checkValue("pwm", expectedPwm(), pwmOut);
            if (report.valid || mReportValid) begin
                checkValue("report valid", mReportValid, report.valid);
                checkValue("lostMag", mReportMag, report.lostMag);
                checkValue("shortfall", mReportShort, report.shortfall);
                reportsSeen++;
            end
        end
        advanceModel(reset, cfg, step);
    end

    // width of the last finished pulse
    always @(negedge clk) begin
        if (reset) begin
            runLen = 0;
        end else if (pwmOut === 1'b1) begin
            runLen++;
        end else if (runLen != 0) begin
            lastPulseWidth = runLen;
            runLen = 0;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: the run went past %0d cycles", cycleLimit);
            $display("Something failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    initial begin
        int plannedCycles;
        clk            = 1'b0;
        reset          = 1'b1;
        cfg.enable     = 1'b0;
        cfg.periodLen  = 12'd100;
        step.pulseLen  = 16'd50;
        step.stepStart = 1'b0;
        step.stepEnd   = 1'b0;
        testName       = "reset";
        cycleCount     = 0;
        reportsSeen    = 0;
        runLen         = 0;
        lastPulseWidth = 0;

        // random steps are drawn up front so the cycle limit covers them
        plannedCycles = 3 + IdleCycles + 1 + SteadyLen + DeferLen + CarryLen;
        plannedCycles += CutLen + ShortLen + 1 + 1 + TailCycles;
        rngState = 32'd64;
        for (int k = 0; k < RandomSteps; k++) begin
            rngState     = xorshift(rngState);
            randPulse[k] = 16'(1 + rngState % 60);
            rngState     = xorshift(rngState);
            randLen[k]   = 40 + int'(rngState % 361);
            plannedCycles += randLen[k];
        end
        cycleLimit = plannedCycles + plannedCycles / 5;

        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // strobes while disabled must not move anything
        testName = "idle";
        runStep(16'd50, IdleCycles / 2);
        runStep(16'd70, IdleCycles / 2);
        setConfig(1'b1, 64);

        testName = "steady";
        runStep(16'd40, SteadyLen);
        checkValue("pulse width", 40, lastPulseWidth);

        // 12 per period fires 36 every third period
        testName = "deferral";
        runStep(16'd12, DeferLen);
        checkValue("pulse width", 36, lastPulseWidth);
        testName = "carried remainder";
        runStep(16'd12, CarryLen);

        // the next step start cuts the pulse after 16 cycles
        testName = "restart";
        runStep(16'd40, CutLen);
        // long enough for the restarted timer to tick once
        runStep(16'd40, ShortLen);
        checkValue("cut pulse width", 16, lastPulseWidth);

        testName = "random";
        setConfig(1'b1, 50);
        for (int k = 0; k < RandomSteps; k++) begin
            runStep(randPulse[k], randLen[k]);
        end
        setConfig(1'b0, 50);
        repeat (TailCycles) @(posedge clk);

        testName = "report count";
        checkValue("reports", ExpectedReports, reportsSeen);
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+design
+incdir+tb
design/pwmGenPkg.sv
design/periodTimer.sv
design/pwmSequencer.sv
design/remainderAccumulator.sv
design/onTimeCounter.sv
design/lossMeter.sv
design/pwmGenerator.sv
tb/pwmGeneratorTb.sv
